//--- cpuProject.f
src/cpuPkg.sv
src/instrFetch.sv
src/controlUnit.sv
src/regDecode.sv
src/execUnit.sv
src/memOrIo.sv
src/cpuTop.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module cpuTb -o cpuSim -f cpuProject.f
./obj_dir/cpuSim 2>&1 | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1

//--- program.hex
// one 32-bit instruction word per line, word address = line index
// loop: scale switch by 5 into led low, triangle sum of switch[3:0] into led high
8C01FC70 // 00 lw   $1, 0xfc70($0)   read switch
AC010010 // 04 sw   $1, 0x10($0)     park it in ram
8C020010 // 08 lw   $2, 0x10($0)     and load it back
00021880 // 0c sll  $3, $2, 2
00621820 // 10 add  $3, $3, $2       5 * s
AC03FC60 // 14 sw   $3, 0xfc60($0)   led bits 15:0
3044000F // 18 andi $4, $2, 15       n
0C00000A // 1c jal  0x28
AC05FC64 // 20 sw   $5, 0xfc64($0)   led bits 23:16
08000000 // 24 j    0x00
00002820 // 28 add  $5, $0, $0       sum = 0
10800003 // 2c beq  $4, $0, 0x3c     nothing to add
00A42820 // 30 add  $5, $5, $4
2084FFFF // 34 addi $4, $4, -1
1480FFFD // 38 bne  $4, $0, 0x30
03E00008 // 3c jr   $31

//--- testbench/cpuTb.sv
module cpuTb;
    import cpuPkg::*;

    localparam int          halfPeriod  = 5;
    localparam int          resetCycles = 16;
    localparam int          ledTimeout  = 2000;
    localparam int          randomCount = 20;
    localparam logic [31:0] lcgSeed     = 32'h71fe;

    logic                   clk;
    logic                   arstN;
    logic [ioDataWidth-1:0] switch;
    logic [ledWidth-1:0]    led;

    // value before the current one while a store may still be in flight
    logic [ioDataWidth-1:0] prevSwitch;
    logic [31:0]            lcgState;
    // first edge only loads the reset values
    logic                   clkSeen = 1'b0;

    logic [15:0] ledLow;
    logic [7:0]  ledHigh;
    logic [15:0] lowNow;
    logic [15:0] lowPrev;
    logic [7:0]  sumNow;
    logic [7:0]  sumPrev;

    cpuTop u_cpuTop (
        .clk    (clk),
        .arstN  (arstN),
        .switch (switch),
        .led    (led)
    );

    ////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////
    // led low is 5 * s wrapped to 16 bits
    function automatic logic [15:0] scaleBy5(input logic [15:0] s);
        return s * 16'd5;
    endfunction

    // 1 + 2 + ... + n with n = s[3:0] and at most 120
    function automatic logic [7:0] triangleSum(input logic [15:0] s);
        logic [7:0] n;
        n = {4'h0, s[3:0]};
        return (n * (n + 8'd1)) >> 1;
    endfunction

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    assign ledLow  = led[15:0];
    assign ledHigh = led[23:16];
    assign lowNow  = scaleBy5(switch);
    assign lowPrev = scaleBy5(prevSwitch);
    assign sumNow  = triangleSum(switch);
    assign sumPrev = triangleSum(prevSwitch);

    ////////////////////////////////////////////////////////////
    // clock and helpers
    ////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    always @(posedge clk) begin
        clkSeen <= 1'b1;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first failing check");
    endtask

    // new value on the falling edge
    task automatic applySwitch(input logic [15:0] value);
        @(negedge clk);
        prevSwitch = switch;
        switch     = value;
    endtask

    // both halves with a timeout each
    task automatic waitForLeds(input logic [15:0] s);
        logic [15:0] expLow;
        logic [7:0]  expHigh;
        int          cycles;
        expLow  = scaleBy5(s);
        expHigh = triangleSum(s);
        cycles  = 0;
        while (ledLow !== expLow && cycles < ledTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (ledLow !== expLow) begin
            stopWithError($sformatf(
                "error at %0t: led[15:0] expected %h, got %h (switch %h, %0d cycles)",
                $time, expLow, ledLow, s, ledTimeout));
        end
        cycles = 0;
        while (ledHigh !== expHigh && cycles < ledTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (ledHigh !== expHigh) begin
            stopWithError($sformatf(
                "error at %0t: led[23:16] expected %h, got %h (switch %h, %0d cycles)",
                $time, expHigh, ledHigh, s, ledTimeout));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////
    resetLedsOff: assert property (@(posedge clk) (!arstN && clkSeen) |-> led == '0)
        else stopWithError($sformatf("error at %0t: led expected %h, got %h",
            $time, 24'h0, $sampled(led)));

    // edge of release and the cycle after it
    releaseLedsOff: assert property (@(posedge clk) $rose(arstN) |-> led == '0)
        else stopWithError($sformatf("error at %0t: led expected %h, got %h",
            $time, 24'h0, $sampled(led)));
    firstCycleLedsOff: assert property (@(posedge clk) $rose(arstN) |=> led == '0)
        else stopWithError($sformatf("error at %0t: led expected %h, got %h",
            $time, 24'h0, $sampled(led)));

    // every new low value comes from the current or the previous switch
    lowFollowsSwitch: assert property (@(posedge clk) disable iff (!arstN)
        $changed(ledLow) |-> (ledLow == lowNow) || (ledLow == lowPrev))
        else stopWithError($sformatf("error at %0t: led[15:0] expected %h or %h, got %h",
            $time, $sampled(lowNow), $sampled(lowPrev), $sampled(ledLow)));

    highFollowsSwitch: assert property (@(posedge clk) disable iff (!arstN)
        $changed(ledHigh) |-> (ledHigh == sumNow) || (ledHigh == sumPrev))
        else stopWithError($sformatf("error at %0t: led[23:16] expected %h or %h, got %h",
            $time, $sampled(sumNow), $sampled(sumPrev), $sampled(ledHigh)));

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        arstN      = 1'b0;
        // nonzero so the later 0 needs a real pass of the loop
        switch     = 16'h0003;
        prevSwitch = 16'h0003;
        lcgState   = lcgSeed;

        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
        end
        arstN = 1'b1;
        waitForLeds(switch);

        // beq skip path
        applySwitch(16'h0000);
        waitForLeds(switch);
        // low half wraps and n = 15
        applySwitch(16'hffff);
        waitForLeds(switch);
        // largest sum again with a small low value
        applySwitch(16'h000f);
        waitForLeds(switch);

        for (int i = 0; i < randomCount; i++) begin
            lcgState = lcgNext(lcgState);
            // upper bits of the lcg are the better ones
            applySwitch(lcgState[31:16]);
            waitForLeds(switch);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- src/cpuTop.sv
module cpuTop (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [cpuPkg::ioDataWidth-1:0]  switch,
    output logic [cpuPkg::ledWidth-1:0]     led
);
    import cpuPkg::*;

    // fetch
    word_t instr;
    word_t pcPlus4;
    word_t linkAddr;
    // decode
    ctrl_t ctrl;
    word_t readData1;
    word_t readData2;
    word_t signExt;
    // execute and memory
    word_t aluResult;
    logic  zero;
    word_t branchTarget;
    word_t loadData;

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////
    instrFetch u_instrFetch (
        .clk          (clk),
        .arstN        (arstN),
        .ctrl         (ctrl),
        .zero         (zero),
        .branchTarget (branchTarget),
        .readData1    (readData1),
        .instr        (instr),
        .pcPlus4      (pcPlus4),
        .linkAddr     (linkAddr)
    );

    // io window decode uses the address bits
    controlUnit u_controlUnit (
        .instr         (instr),
        .aluResultHigh (aluResult[31:10]),
        .ctrl          (ctrl)
    );

    regDecode u_regDecode (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .loadData  (loadData),
        .linkAddr  (linkAddr),
        .readData1 (readData1),
        .readData2 (readData2),
        .signExt   (signExt)
    );

    execUnit u_execUnit (
        .instr        (instr),
        .ctrl         (ctrl),
        .readData1    (readData1),
        .readData2    (readData2),
        .signExt      (signExt),
        .pcPlus4      (pcPlus4),
        .aluResult    (aluResult),
        .zero         (zero),
        .branchTarget (branchTarget)
    );

    // rt supplies the store data
    memOrIo u_memOrIo (
        .clk       (clk),
        .arstN     (arstN),
        .memRead   (ctrl.memRead),
        .memWrite  (ctrl.memWrite),
        .ioRead    (ctrl.ioRead),
        .ioWrite   (ctrl.ioWrite),
        .addr      (aluResult),
        .storeData (readData2),
        .switch    (switch),
        .loadData  (loadData),
        .led       (led)
    );

endmodule

//--- src/memOrIo.sv
module memOrIo (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              memRead,
    input  logic                              memWrite,
    input  logic                              ioRead,
    input  logic                              ioWrite,
    input  cpuPkg::word_t                     addr,
    input  cpuPkg::word_t                     storeData,
    input  logic [cpuPkg::ioDataWidth-1:0]    switch,
    output cpuPkg::word_t                     loadData,
    output logic [cpuPkg::ledWidth-1:0]       led
);
    import cpuPkg::*;

    logic [$clog2(ramDepth)-1:0]      ramIdx;
    logic [ioDataWidth-1:0]           ledLow;
    logic [ledWidth-ioDataWidth-1:0]  ledHigh;
    logic                             switchSel;

    word_t ram [ramDepth];

    ////////////////////////////////////////////////////////////
    // data ram
    ////////////////////////////////////////////////////////////
    // byte address to word index
    assign ramIdx = addr[$clog2(ramDepth)+1:2];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            ram[ramIdx] <= storeData;
        end
    end

    ////////////////////////////////////////////////////////////
    // load path
    ////////////////////////////////////////////////////////////
    assign switchSel = ioRead && (addr == switchAddr);

    always_comb begin
        if (memRead) begin
            loadData = ram[ramIdx];
        end else if (switchSel) begin
            // switches read zero extended
            loadData = {{(dataWidth-ioDataWidth){1'b0}}, switch};
        end else begin
            loadData = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // led registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ledLow  <= '0;
            ledHigh <= '0;
        end else if (ioWrite) begin
            if (addr == ledLowAddr) begin
                ledLow <= storeData[ioDataWidth-1:0];
            end
            // upper bank takes the low byte of the store
            if (addr == ledHighAddr) begin
                ledHigh <= storeData[ledWidth-ioDataWidth-1:0];
            end
        end
    end

    assign led = {ledHigh, ledLow};

    // program only stores to the two led ports
    ledTarget: assert property (@(posedge clk) disable iff (!arstN)
        ioWrite |-> (addr == ledLowAddr) || (addr == ledHighAddr))
        else $error("io write to unmapped address %h", addr);

endmodule

//--- src/execUnit.sv
module execUnit (
    input  cpuPkg::word_t  instr,
    input  cpuPkg::ctrl_t  ctrl,
    input  cpuPkg::word_t  readData1,
    input  cpuPkg::word_t  readData2,
    input  cpuPkg::word_t  signExt,
    input  cpuPkg::word_t  pcPlus4,
    output cpuPkg::word_t  aluResult,
    output logic           zero,
    output cpuPkg::word_t  branchTarget
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    word_t      opB;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // funct bit 2 picks the variable form
    assign shamt = funct[2] ? readData1[4:0] : instr[10:6];

    // immediate for i-format and lw/sw
    assign opB = ctrl.aluSrc ? signExt : readData2;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////
    always_comb begin
        aluResult = '0;
        case (ctrl.aluOp)
            aluAdd: aluResult = readData1 + opB;
            aluSub: aluResult = readData1 - opB;
            aluFunc: begin
                if (ctrl.sftmd) begin
                    // shifter works on rt
                    case (funct[1:0])
                        fnSll[1:0]: aluResult = readData2 << shamt;
                        fnSrl[1:0]: aluResult = readData2 >> shamt;
                        fnSra[1:0]: aluResult = $signed(readData2) >>> shamt;
                        default:    aluResult = '0;
                    endcase
                end else if (ctrl.iFormat) begin
                    case (opcode)
                        opAddi, opAddiu: aluResult = readData1 + opB;
                        opSlti:  aluResult = {31'b0, $signed(readData1) < $signed(opB)};
                        opSltiu: aluResult = {31'b0, readData1 < opB};
                        opAndi:  aluResult = readData1 & opB;
                        opOri:   aluResult = readData1 | opB;
                        opXori:  aluResult = readData1 ^ opB;
                        opLui:   aluResult = {opB[15:0], 16'h0000};
                        default: aluResult = '0;
                    endcase
                end else begin
                    case (funct)
                        fnAdd, fnAddu: aluResult = readData1 + opB;
                        fnSub, fnSubu: aluResult = readData1 - opB;
                        fnAnd:  aluResult = readData1 & opB;
                        fnOr:   aluResult = readData1 | opB;
                        fnXor:  aluResult = readData1 ^ opB;
                        fnNor:  aluResult = ~(readData1 | opB);
                        fnSlt:  aluResult = {31'b0, $signed(readData1) < $signed(opB)};
                        fnSltu: aluResult = {31'b0, readData1 < opB};
                        // jr and unknown codes
                        default: aluResult = '0;
                    endcase
                end
            end
            default: aluResult = '0;
        endcase
    end

    // rs minus rt on branches
    assign zero = (aluResult == '0);

    // offset in words from the next instruction
    assign branchTarget = pcPlus4 + {signExt[29:0], 2'b00};

endmodule

//--- src/regDecode.sv
module regDecode (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::word_t  instr,
    input  cpuPkg::ctrl_t  ctrl,
    input  cpuPkg::word_t  aluResult,
    input  cpuPkg::word_t  loadData,
    input  cpuPkg::word_t  linkAddr,
    output cpuPkg::word_t  readData1,
    output cpuPkg::word_t  readData2,
    output cpuPkg::word_t  signExt
);
    import cpuPkg::*;

    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] wAddr;
    word_t                   wData;
    logic [5:0]              opcode;
    logic                    zeroExt;

    word_t regs [2**regAddrWidth];

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    ////////////////////////////////////////////////////////////
    // read ports and immediate
    ////////////////////////////////////////////////////////////
    // $0 is never written
    assign readData1 = regs[rs];
    assign readData2 = regs[rt];

    // logical immediates are unsigned
    assign zeroExt = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
    assign signExt = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    ////////////////////////////////////////////////////////////
    // write back
    ////////////////////////////////////////////////////////////
    // jal links into $31
    assign wAddr = ctrl.jal ? 5'd31 : (ctrl.regDst ? rd : rt);

    always_comb begin
        if (ctrl.jal) begin
            wData = linkAddr;
        end else if (ctrl.memOrIoToReg) begin
            wData = loadData;
        end else begin
            wData = aluResult;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

//--- src/controlUnit.sv
module controlUnit (
    input  cpuPkg::word_t  instr,
    input  logic [21:0]    aluResultHigh,
    output cpuPkg::ctrl_t  ctrl
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       rFormat;
    logic       iFormat;
    logic       isLw;
    logic       isSw;
    logic       isJr;
    logic       ioHit;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    ////////////////////////////////////////////////////////////
    // instruction classes
    ////////////////////////////////////////////////////////////
    assign rFormat = (opcode == opR);
    // addi through lui share opcode prefix 001
    assign iFormat = (opcode[5:3] == 3'b001);
    assign isLw    = (opcode == opLw);
    assign isSw    = (opcode == opSw);
    assign isJr    = rFormat && (funct == fnJr);

    // effective address falls in the io window
    assign ioHit = (aluResultHigh == ioBaseHigh);

    ////////////////////////////////////////////////////////////
    // control fields
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl          = '0;
        ctrl.jr       = isJr;
        // rd for r-format and rt otherwise
        ctrl.regDst   = rFormat;
        ctrl.aluSrc   = iFormat || isLw || isSw;
        ctrl.regWrite = (rFormat && !isJr) || iFormat || isLw || (opcode == opJal);

        // loads and stores split between ram and io
        ctrl.memWrite     = isSw && !ioHit;
        ctrl.ioWrite      = isSw && ioHit;
        ctrl.memRead      = isLw && !ioHit;
        ctrl.ioRead       = isLw && ioHit;
        ctrl.memOrIoToReg = isLw;

        ctrl.branch  = (opcode == opBeq);
        ctrl.nBranch = (opcode == opBne);
        ctrl.jmp     = (opcode == opJ);
        ctrl.jal     = (opcode == opJal);
        ctrl.iFormat = iFormat;

        // sll through srav
        ctrl.sftmd = rFormat && (funct[5:3] == 3'b000);

        if (rFormat || iFormat) begin
            ctrl.aluOp = aluFunc;
        end else if (ctrl.branch || ctrl.nBranch) begin
            ctrl.aluOp = aluSub;
        end else begin
            ctrl.aluOp = aluAdd;
        end
    end

endmodule

//--- src/instrFetch.sv
module instrFetch (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::ctrl_t  ctrl,
    input  logic           zero,
    input  cpuPkg::word_t  branchTarget,
    input  cpuPkg::word_t  readData1,
    output cpuPkg::word_t  instr,
    output cpuPkg::word_t  pcPlus4,
    output cpuPkg::word_t  linkAddr
);
    import cpuPkg::*;

    word_t pc;
    word_t pcNext;
    word_t jumpTarget;
    logic  takeBranch;

    // program image, fixed at elaboration
    word_t rom [romDepth];

    initial begin
        $readmemh("program.hex", rom);
    end

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////
    // word index from pc
    assign instr   = rom[pc[$clog2(romDepth)+1:2]];
    assign pcPlus4 = pc + 32'd4;

    // jal writes the return address into $31
    assign linkAddr = pcPlus4;

    // pseudo-direct target, upper nibble kept
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

    // beq on equal, bne on not equal
    assign takeBranch = (ctrl.branch && zero) || (ctrl.nBranch && !zero);

    ////////////////////////////////////////////////////////////
    // next pc
    ////////////////////////////////////////////////////////////
    always_comb begin
        pcNext = pcPlus4;
        if (ctrl.jr) begin
            pcNext = readData1;
        end else if (ctrl.jmp || ctrl.jal) begin
            pcNext = jumpTarget;
        end else if (takeBranch) begin
            pcNext = branchTarget;
        end
    end

    // one instruction per cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // jr source register must hold an aligned address
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // widths and depths
    ////////////////////////////////////////////////////////////
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int romDepth     = 256;
    localparam int ramDepth     = 256;
    localparam int ioDataWidth  = 16;
    localparam int ledWidth     = 24;

    // alu result bits [31:10] all ones select the io window
    localparam logic [21:0] ioBaseHigh = '1;
    localparam logic [31:0] switchAddr  = 32'hFFFF_FC70;
    localparam logic [31:0] ledLowAddr  = 32'hFFFF_FC60;
    localparam logic [31:0] ledHighAddr = 32'hFFFF_FC64;

    ////////////////////////////////////////////////////////////
    // opcodes and function codes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] opR     = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // shifts occupy funct 0..7
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////
    typedef logic [dataWidth-1:0] word_t;

    // add for lw/sw, sub for beq/bne, funct or opcode otherwise
    typedef enum logic [1:0] {
        aluAdd  = 2'b00,
        aluSub  = 2'b01,
        aluFunc = 2'b10
    } aluOp_t;

    typedef struct packed {
        logic   jr;
        logic   regDst;
        logic   aluSrc;
        logic   regWrite;
        logic   memWrite;
        logic   memRead;
        logic   ioRead;
        logic   ioWrite;
        logic   memOrIoToReg;
        logic   branch;
        logic   nBranch;
        logic   jmp;
        logic   jal;
        logic   iFormat;
        logic   sftmd;
        aluOp_t aluOp;
    } ctrl_t;

endpackage
